/* vlog.f */
+incdir+hdl
hdl/bt656_pkg.sv
hdl/bt656_timing_if.sv
hdl/bt656_timing_decoder.sv
hdl/bt656_line_tracker.sv
hdl/video_byte_fifo.sv
hdl/bt656_rx_top.sv
verification/bt656_rx_tb.sv

/* Bender.yml */
package:
  name: bt656_rx

export_include_dirs:
  - hdl

sources:
  - hdl/bt656_pkg.sv
  - hdl/bt656_timing_if.sv
  - hdl/bt656_timing_decoder.sv
  - hdl/bt656_line_tracker.sv
  - hdl/video_byte_fifo.sv
  - hdl/bt656_rx_top.sv
  - target: test
    files:
      - verification/bt656_rx_tb.sv

/* verification/bt656_rx_tb.sv */
module bt656_rx_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int KIND_STREAM = 0;
   localparam int KIND_SIZE   = 1;
   localparam int KIND_FLAG   = 2;
   localparam int HBLANK_LEN  = 8;

   logic        clk = 1'b0;
   logic        rstn;
   logic [7:0]  video_data_i;
   logic [7:0]  m_axis_tdata_o;
   logic        m_axis_tvalid_o;
   logic        m_axis_tready_i;
   logic        m_axis_tuser_o;
   logic        m_axis_tlast_o;
   logic [11:0] frame_width_o;
   logic [11:0] frame_height_o;
   logic        size_valid_o;
   logic        width_err_o;
   logic        height_err_o;
   logic        overflow_o;
   logic        clear_errors_i;

   integer      seed = 32'h2ce8a2b1;
   int          errs [3];
   logic        hold_ready;
   logic        model_en;

   // Reference model state
   logic [9:0]  exp_q [$];
   logic [23:0] size_q [$];
   logic        last_f;
   logic        seen_frame;
   logic        sof_next;
   int          cur_w;
   int          cur_h;

   bt656_rx_top dut
     (
      .clk             (clk),
      .rstn            (rstn),
      .video_data_i    (video_data_i),
      .m_axis_tdata_o  (m_axis_tdata_o),
      .m_axis_tvalid_o (m_axis_tvalid_o),
      .m_axis_tready_i (m_axis_tready_i),
      .m_axis_tuser_o  (m_axis_tuser_o),
      .m_axis_tlast_o  (m_axis_tlast_o),
      .frame_width_o   (frame_width_o),
      .frame_height_o  (frame_height_o),
      .size_valid_o    (size_valid_o),
      .width_err_o     (width_err_o),
      .height_err_o    (height_err_o),
      .overflow_o      (overflow_o),
      .clear_errors_i  (clear_errors_i)
      );

   always #10 clk = ~clk;

   // Bytes in a frame of two blanking lines, the active lines and a closing blanking line
   // Each line holds EAV, horizontal blanking, SAV and the pixel bytes
   function automatic int frame_bytes(input int w, input int h);
      return (h + 3) * (8 + HBLANK_LEN + 2 * w);
   endfunction

   function automatic int stimulus_bytes();
      return 5 * frame_bytes(8, 4) + frame_bytes(8, 5) + frame_bytes(40, 16);
   endfunction

   // XY byte with protection bits
   function automatic logic [7:0] xy_byte(input logic f, input logic v, input logic h);
      return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h};
   endfunction

   function automatic logic [7:0] rand_pixel();
      logic [7:0] b;
      do
         b = $random(seed);
      while (b == 8'hFF || b == 8'h00);
      return b;
   endfunction

   task automatic check_equal(input string name, input logic [15:0] got,
                              input logic [15:0] exp, input int kind);
      assert (got === exp)
      else
      begin
         errs[kind]++;
         $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic print_counts();
      $display("errors: stream %0d, size %0d, flags %0d", errs[0], errs[1], errs[2]);
   endtask

   // One byte per cycle with ready randomized in the same step
   task automatic drive_byte(input logic [7:0] b);
      @(posedge clk);
      #2;
      video_data_i = b;
      if (hold_ready)
         m_axis_tready_i = 1'b0;
      else
         m_axis_tready_i = (($random(seed) & 3) != 0);
   endtask

   task automatic send_fill(input int n);
      for (int i = 0; i < n; i++)
      begin
         drive_byte(i[0] ? 8'h10 : 8'h80);
      end
   endtask

   task automatic send_header(input logic f, input logic v, input logic h);
      // Falling F starts a new frame and closes the previous one
      if (last_f && !f)
      begin
         if (seen_frame)
            size_q.push_back({cur_w[11:0], cur_h[11:0]});
         seen_frame = 1'b1;
         sof_next   = 1'b1;
         cur_h      = 0;
      end
      last_f = f;
      drive_byte(8'hFF);
      drive_byte(8'h00);
      drive_byte(8'h00);
      drive_byte(xy_byte(f, v, h));
   endtask

   task automatic send_line(input logic f, input logic v, input int npix, input logic active);
      logic [7:0] px;
      send_header(f, v, 1'b1);
      send_fill(HBLANK_LEN);
      send_header(f, v, 1'b0);
      if (!active)
         send_fill(2 * npix);
      else
      begin
         for (int i = 0; i < 2 * npix; i++)
         begin
            px = rand_pixel();
            if (model_en)
               exp_q.push_back({(i == 2 * npix - 1), sof_next, px});
            sof_next = 1'b0;
            drive_byte(px);
         end
         cur_w = npix;
         cur_h++;
      end
   endtask

   // short_line is the index of a line sent 2 pixels short or -1 for none
   task automatic send_frame(input int w, input int h, input int short_line);
      send_line(1'b1, 1'b1, w, 1'b0);
      send_line(1'b0, 1'b1, w, 1'b0);
      for (int l = 0; l < h; l++)
      begin
         send_line(1'b0, 1'b0, (l == short_line) ? w - 2 : w, 1'b1);
      end
      // The EAV of this line closes the last active line
      send_line(1'b1, 1'b1, w, 1'b0);
   endtask

   task automatic apply_reset();
      rstn       = 1'b0;
      last_f     = 1'b0;
      seen_frame = 1'b0;
      sof_next   = 1'b0;
      cur_w      = 0;
      cur_h      = 0;
      send_fill(2);
      rstn = 1'b1;
   endtask

   task automatic pulse_clear();
      clear_errors_i = 1'b1;
      send_fill(1);
      clear_errors_i = 1'b0;
      send_fill(2);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 4000)
      begin
         send_fill(1);
         n++;
      end
      assert (exp_q.size() == 0)
      else
      begin
         errs[KIND_STREAM]++;
         $display("stream output did not drain, %0d bytes never came out", exp_q.size());
      end
   endtask

   task automatic check_transfer();
      logic [9:0] exp;
      assert (exp_q.size() != 0)
      else
      begin
         errs[KIND_STREAM]++;
         $display("stream carried byte %h while no active byte was pending", m_axis_tdata_o);
      end
      if (exp_q.size() != 0)
      begin
         exp = exp_q.pop_front();
         check_equal("m_axis_tdata_o", m_axis_tdata_o, exp[7:0], KIND_STREAM);
         check_equal("m_axis_tuser_o", m_axis_tuser_o, exp[8], KIND_STREAM);
         check_equal("m_axis_tlast_o", m_axis_tlast_o, exp[9], KIND_STREAM);
      end
   endtask

   task automatic check_size();
      logic [23:0] exp;
      assert (size_q.size() != 0)
      else
      begin
         errs[KIND_SIZE]++;
         $display("size_valid_o pulsed with no finished frame to report");
      end
      if (size_q.size() != 0)
      begin
         exp = size_q.pop_front();
         check_equal("frame_width_o", frame_width_o, exp[23:12], KIND_SIZE);
         check_equal("frame_height_o", frame_height_o, exp[11:0], KIND_SIZE);
      end
   endtask

   // Output side sampled at the clock edge
   always @(posedge clk)
   begin
      if (rstn && m_axis_tvalid_o && m_axis_tready_i)
         check_transfer();
      if (rstn && size_valid_o)
         check_size();
   end

   initial
   begin
      int limit;
      limit = 4 * stimulus_bytes() + 2000;
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      print_counts();
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      rstn            = 1'b0;
      video_data_i    = 8'h80;
      m_axis_tready_i = 1'b0;
      clear_errors_i  = 1'b0;
      hold_ready      = 1'b0;
      model_en        = 1'b1;
      apply_reset();
      send_fill(8);

      // Three regular frames with random back-pressure
      for (int k = 0; k < 3; k++)
      begin
         send_frame(8, 4, -1);
      end
      check_equal("width_err_o", width_err_o, 1'b0, KIND_FLAG);
      check_equal("height_err_o", height_err_o, 1'b0, KIND_FLAG);
      check_equal("overflow_o", overflow_o, 1'b0, KIND_FLAG);

      // Short line followed by a clear
      send_frame(8, 4, 1);
      check_equal("width_err_o", width_err_o, 1'b1, KIND_FLAG);
      check_equal("height_err_o", height_err_o, 1'b0, KIND_FLAG);
      pulse_clear();
      check_equal("width_err_o", width_err_o, 1'b0, KIND_FLAG);

      // Extra active line is seen when the next frame starts
      send_frame(8, 5, -1);
      send_frame(8, 4, -1);
      check_equal("height_err_o", height_err_o, 1'b1, KIND_FLAG);
      check_equal("width_err_o", width_err_o, 1'b0, KIND_FLAG);
      wait_drain();

      // Stalled output with a frame larger than the FIFO
      hold_ready      = 1'b1;
      m_axis_tready_i = 1'b0;
      model_en        = 1'b0;
      send_frame(40, 16, -1);
      send_fill(4);
      check_equal("overflow_o", overflow_o, 1'b1, KIND_FLAG);
      check_equal("m_axis_tvalid_o", m_axis_tvalid_o, 1'b1, KIND_FLAG);
      apply_reset();
      check_equal("overflow_o", overflow_o, 1'b0, KIND_FLAG);
      check_equal("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0, KIND_FLAG);
      check_equal("size_valid_o", size_valid_o, 1'b0, KIND_FLAG);
      check_equal("width_err_o", width_err_o, 1'b0, KIND_FLAG);
      check_equal("height_err_o", height_err_o, 1'b0, KIND_FLAG);
      hold_ready = 1'b0;
      send_fill(4);

      assert (size_q.size() == 0)
      else
      begin
         errs[KIND_SIZE]++;
         $display("%0d expected size reports never appeared", size_q.size());
      end

      print_counts();
      if (errs[0] + errs[1] + errs[2] == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* hdl/bt656_rx_top.sv */
`include "bt656_defs.svh"

module bt656_rx_top
  (
   input  logic                   clk,
   input  logic                   rstn,

   // BT.656 input
   input  bt656_pkg::video_byte_t video_data_i,

   // AXI4-Stream output
   output bt656_pkg::video_byte_t m_axis_tdata_o,
   output logic                   m_axis_tvalid_o,
   input  logic                   m_axis_tready_i,
   output logic                   m_axis_tuser_o,
   output logic                   m_axis_tlast_o,

   // Measured frame size
   output bt656_pkg::dim_cnt_t    frame_width_o,
   output bt656_pkg::dim_cnt_t    frame_height_o,
   output logic                   size_valid_o,

   // Sticky error flags
   output logic                   width_err_o,
   output logic                   height_err_o,
   output logic                   overflow_o,
   input  logic                   clear_errors_i
   );

   import bt656_pkg::*;

   // Tag positions above the byte in a FIFO word
   localparam int SOF_BIT = $bits(video_byte_t);
   localparam int EOL_BIT = SOF_BIT + 1;

   logic                     fifo_wr;
   logic                     fifo_full;
   logic [`BT656_DATA_W+1:0] fifo_wdata;
   logic [`BT656_DATA_W+1:0] fifo_rdata;

   bt656_timing_if tim ();

   bt656_timing_decoder u_decoder
     (
      .clk          (clk),
      .rstn         (rstn),
      .video_data_i (video_data_i),
      .tim_o        (tim)
      );

   bt656_line_tracker u_tracker
     (
      .clk            (clk),
      .rstn           (rstn),
      .tim_i          (tim),
      .fifo_wr_o      (fifo_wr),
      .fifo_wdata_o   (fifo_wdata),
      .fifo_full_i    (fifo_full),
      .clear_errors_i (clear_errors_i),
      .frame_width_o  (frame_width_o),
      .frame_height_o (frame_height_o),
      .size_valid_o   (size_valid_o),
      .width_err_o    (width_err_o),
      .height_err_o   (height_err_o),
      .overflow_o     (overflow_o)
      );

   video_byte_fifo
     #(
       .AW (`BT656_FIFO_AW)
       )
   u_fifo
     (
      .clk      (clk),
      .rstn     (rstn),
      .wr_i     (fifo_wr),
      .wdata_i  (fifo_wdata),
      .full_o   (fifo_full),
      .rvalid_o (m_axis_tvalid_o),
      .rready_i (m_axis_tready_i),
      .rdata_o  (fifo_rdata)
      );

   assign m_axis_tdata_o = fifo_rdata[SOF_BIT-1:0];
   assign m_axis_tuser_o = fifo_rdata[SOF_BIT];
   assign m_axis_tlast_o = fifo_rdata[EOL_BIT];

endmodule

/* hdl/video_byte_fifo.sv */
`include "bt656_defs.svh"

module video_byte_fifo
  #(
    parameter int AW = 4
    )
  (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     wr_i,
   input  logic [`BT656_DATA_W+1:0] wdata_i,
   output logic                     full_o,
   output logic                     rvalid_o,
   input  logic                     rready_i,
   output logic [`BT656_DATA_W+1:0] rdata_o
   );

   import bt656_pkg::*;

   // Video byte plus the sof and eol tags
   localparam int WORD_W = $bits(video_byte_t) + 2;
   localparam int DEPTH  = 1 << AW;

   logic [WORD_W-1:0] mem [DEPTH];
   logic [AW:0]       wr_ptr;
   logic [AW:0]       rd_ptr;
   logic              do_wr;
   logic              do_rd;

   // Extra pointer bit tells full from empty
   assign full_o   = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign rvalid_o = (wr_ptr != rd_ptr);
   assign do_wr    = wr_i && !full_o;
   assign do_rd    = rvalid_o && rready_i;

   // Head word straight from the array
   assign rdata_o = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr[AW-1:0]] <= wdata_i;
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

/* hdl/bt656_line_tracker.sv */
`include "bt656_defs.svh"

module bt656_line_tracker
  (
   input  logic                     clk,
   input  logic                     rstn,
   bt656_timing_if.dst              tim_i,
   output logic                     fifo_wr_o,
   output logic [`BT656_DATA_W+1:0] fifo_wdata_o,
   input  logic                     fifo_full_i,
   input  logic                     clear_errors_i,
   output bt656_pkg::dim_cnt_t      frame_width_o,
   output bt656_pkg::dim_cnt_t      frame_height_o,
   output logic                     size_valid_o,
   output logic                     width_err_o,
   output logic                     height_err_o,
   output logic                     overflow_o
   );

   import bt656_pkg::*;

   line_state_t           state;
   line_state_t           state_nxt;
   video_byte_t           hold_data;
   logic                  hold_valid;
   logic                  hold_sof;
   logic                  sof_pend;
   logic                  active_byte;
   logic                  line_end;
   logic [`BT656_CNT_W:0] byte_cnt;
   dim_cnt_t              line_width;
   dim_cnt_t              last_width;
   dim_cnt_t              line_cnt;
   dim_cnt_t              lines_now;
   logic                  width_known;
   logic                  height_known;

   assign active_byte = (state == VIDEO) && !tim_i.hdr_byte;
   assign line_end    = (state == VIDEO) && tim_i.eav;

   // Two bytes per pixel
   assign line_width = byte_cnt[`BT656_CNT_W:1];

   // A line may close in the same cycle as the frame
   assign lines_now = line_end ? line_cnt + 1'b1 : line_cnt;

   // FIFO word is {eol, sof, byte}
   assign fifo_wr_o    = hold_valid && (active_byte || line_end);
   assign fifo_wdata_o = {line_end, hold_sof, hold_data};

   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:
            if (tim_i.new_frame)
               state_nxt = WAIT_SAV;
         WAIT_SAV, BLANK:
            if (tim_i.sav)
               state_nxt = tim_i.vblank ? BLANK : VIDEO;
         VIDEO:
            if (tim_i.eav)
               state_nxt = BLANK;
         default:
            state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
         state <= IDLE;
      else
         state <= state_nxt;
   end

   always_ff @(posedge clk)
   begin
      if (active_byte)
         hold_data <= tim_i.data;
   end

   // One byte held back so the line end can be tagged
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         hold_valid <= 1'b0;
         hold_sof   <= 1'b0;
         sof_pend   <= 1'b0;
      end
      else
      begin
         if (active_byte)
         begin
            hold_valid <= 1'b1;
            hold_sof   <= sof_pend;
            sof_pend   <= 1'b0;
         end
         else if (line_end)
            hold_valid <= 1'b0;
         if (tim_i.new_frame)
            sof_pend <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         byte_cnt       <= '0;
         line_cnt       <= '0;
         last_width     <= '0;
         width_known    <= 1'b0;
         height_known   <= 1'b0;
         frame_width_o  <= '0;
         frame_height_o <= '0;
         size_valid_o   <= 1'b0;
         width_err_o    <= 1'b0;
         height_err_o   <= 1'b0;
         overflow_o     <= 1'b0;
      end
      else
      begin
         size_valid_o <= 1'b0;
         if (clear_errors_i)
         begin
            width_err_o  <= 1'b0;
            height_err_o <= 1'b0;
            overflow_o   <= 1'b0;
         end

         if (tim_i.sav)
            byte_cnt <= '0;
         else if (active_byte)
            byte_cnt <= byte_cnt + 1'b1;

         // Compare each line with the one before it
         if (line_end)
         begin
            if (width_known && (line_width != last_width))
               width_err_o <= 1'b1;
            last_width  <= line_width;
            width_known <= 1'b1;
         end

         if (tim_i.new_frame)
         begin
            line_cnt <= '0;
            // Only a frame that began with a new_frame counts as complete
            if (state != IDLE)
            begin
               if (height_known && (lines_now != frame_height_o))
                  height_err_o <= 1'b1;
               frame_height_o <= lines_now;
               frame_width_o  <= line_end ? line_width : last_width;
               height_known   <= 1'b1;
               size_valid_o   <= 1'b1;
            end
         end
         else if (line_end)
            line_cnt <= line_cnt + 1'b1;

         // The FIFO drops this byte
         if (fifo_wr_o && fifo_full_i)
            overflow_o <= 1'b1;
      end
   end

endmodule

/* hdl/bt656_timing_decoder.sv */
module bt656_timing_decoder
  (
   input  logic                   clk,
   input  logic                   rstn,
   input  bt656_pkg::video_byte_t video_data_i,
   bt656_timing_if.src            tim_o
   );

   import bt656_pkg::*;

   // Bit positions in the XY byte of a timing reference code
   localparam int HDR_BIT_ONE = 7;
   localparam int HDR_BIT_F   = 6;
   localparam int HDR_BIT_V   = 5;
   localparam int HDR_BIT_H   = 4;

   video_byte_t win [4];
   logic        hdr_det;
   logic [1:0]  hdr_left;
   logic        field_q;

   // Index 0 holds the newest byte, index 3 the oldest
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         for (int i = 0; i < 4; i++)
         begin
            win[i] <= '0;
         end
      end
      else
      begin
         win[0] <= video_data_i;
         for (int i = 1; i < 4; i++)
         begin
            win[i] <= win[i-1];
         end
      end
   end

   // FF 00 00 XY with the oldest byte at the FF
   assign hdr_det = (win[3] == 8'hFF) && (win[2] == 8'h00) && (win[1] == 8'h00) &&
                    win[0][HDR_BIT_ONE];

   always_ff @(posedge clk)
   begin
      tim_o.data <= win[3];
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         tim_o.sav       <= 1'b0;
         tim_o.eav       <= 1'b0;
         tim_o.vblank    <= 1'b0;
         tim_o.new_frame <= 1'b0;
         tim_o.hdr_byte  <= 1'b0;
         hdr_left        <= '0;
         field_q         <= 1'b0;
      end
      else
      begin
         tim_o.sav       <= hdr_det && !win[0][HDR_BIT_H];
         tim_o.eav       <= hdr_det && win[0][HDR_BIT_H];
         tim_o.new_frame <= hdr_det && field_q && !win[0][HDR_BIT_F];
         if (hdr_det)
         begin
            tim_o.vblank   <= win[0][HDR_BIT_V];
            field_q        <= win[0][HDR_BIT_F];
            tim_o.hdr_byte <= 1'b1;
            // The 00 00 XY bytes follow the FF
            hdr_left       <= 2'd3;
         end
         else if (hdr_left != '0)
         begin
            tim_o.hdr_byte <= 1'b1;
            hdr_left       <= hdr_left - 1'b1;
         end
         else
            tim_o.hdr_byte <= 1'b0;
      end
   end

endmodule

/* hdl/bt656_timing_if.sv */
`include "bt656_defs.svh"

// Decoded byte stream with its timing strobes, advances every cycle
interface bt656_timing_if;

   logic [`BT656_DATA_W-1:0] data;
   logic                     hdr_byte;
   logic                     sav;
   logic                     eav;
   logic                     vblank;
   logic                     new_frame;

   modport src
   (
      output data, hdr_byte, sav, eav, vblank, new_frame
   );

   modport dst
   (
      input data, hdr_byte, sav, eav, vblank, new_frame
   );

endinterface

/* hdl/bt656_pkg.sv */
`include "bt656_defs.svh"

package bt656_pkg;

   // One byte of the Cb Y Cr Y stream
   typedef logic [`BT656_DATA_W-1:0] video_byte_t;

   // Frame width in pixels or height in lines
   typedef logic [`BT656_CNT_W-1:0] dim_cnt_t;

   // Line tracker FSM
   typedef enum logic [1:0]
   {
      IDLE,
      WAIT_SAV,
      VIDEO,
      BLANK
   } line_state_t;

endpackage

/* hdl/bt656_defs.svh */
`ifndef BT656_DEFS_SVH
`define BT656_DEFS_SVH

// Width of one video byte on the BT.656 bus
`define BT656_DATA_W 8

// Pixel and line counters
`define BT656_CNT_W 12

// Video FIFO address width, 1024 entries
`define BT656_FIFO_AW 10

`endif
